//--- include/control_settings.svh
`ifndef CONTROL_SETTINGS_SVH
`define CONTROL_SETTINGS_SVH

// Instruction cycle counter, longest instruction is a 3 cycle load
`define CU_CYCLE_WIDTH 2

// Flush counter counts down from 3 after reset
`define CU_FLUSH_WIDTH 2

// Register file indexing
`define CU_REG_IDX_WIDTH 4
`define CU_PC_REG 15

// B-bus immediate and barrel shifter amount
`define CU_IMM_WIDTH 12
`define CU_SHIFT_AMT_WIDTH 5

`endif

//--- source/cpu_pkg.sv
`include "control_settings.svh"

package cpu_pkg;

  // ==========================================================================
  // Enumerations
  // ==========================================================================

  typedef enum logic [2:0] {
    instr_none,
    instr_dataproc_imm,
    instr_dataproc_reg_imm,
    instr_dataproc_reg_reg,
    instr_load,
    instr_store
  } instr_type_e;

  // Data processing opcodes in ARM encoding order
  typedef enum logic [3:0] {
    alu_and = 4'd0,
    alu_eor = 4'd1,
    alu_sub = 4'd2,
    alu_rsb = 4'd3,
    alu_add = 4'd4,
    alu_adc = 4'd5,
    alu_sbc = 4'd6,
    alu_rsc = 4'd7,
    alu_tst = 4'd8,
    alu_teq = 4'd9,
    alu_cmp = 4'd10,
    alu_cmn = 4'd11,
    alu_orr = 4'd12,
    alu_mov = 4'd13,
    alu_bic = 4'd14,
    alu_mvn = 4'd15
  } alu_op_e;

  typedef enum logic [1:0] {shift_lsl, shift_lsr, shift_asr, shift_ror} shift_type_e;

  typedef enum logic [1:0] {addr_pc, addr_incr, addr_alu} addr_src_e;

  typedef enum logic [2:0] {
    b_src_imm,
    b_src_reg_rm,
    b_src_reg_rs,
    b_src_reg_rd,
    b_src_read_data
  } b_src_e;

  typedef enum logic [1:0] {alu_wb_none, alu_wb_reg_rd, alu_wb_reg_rn} alu_wb_e;

  typedef enum logic [2:0] {
    phase_reset_prefetch,
    phase_flush_fetch,
    phase_flush_advance,
    phase_skip,
    phase_execute
  } seq_phase_e;

  // ==========================================================================
  // Decoded instruction and control word
  // ==========================================================================

  typedef struct packed {
    instr_type_e                      instr_type;
    logic                             condition_pass;
    logic [`CU_REG_IDX_WIDTH-1:0]     rn;
    logic [`CU_REG_IDX_WIDTH-1:0]     rd;
    logic [`CU_REG_IDX_WIDTH-1:0]     rs;
    logic [`CU_REG_IDX_WIDTH-1:0]     rm;
    alu_op_e                          opcode;
    logic                             set_flags;
    shift_type_e                      shift_type;
    logic [`CU_SHIFT_AMT_WIDTH-1:0]   shift_amount;
    logic [7:0]                       imm8;
    logic [3:0]                       rotate;
    logic [`CU_IMM_WIDTH-1:0]         imm12;
    // Single transfer bits P, U, B, W, I
    logic                             pre_index;
    logic                             up;
    logic                             byte_xfer;
    logic                             writeback;
    logic                             reg_offset;
  } decoded_word_t;

  typedef struct packed {
    logic                             instr_fetch;
    logic                             incrementer_writeback;
    addr_src_e                        addr_src;
    b_src_e                           b_src;
    logic [`CU_IMM_WIDTH-1:0]         b_imm;
    shift_type_e                      shift_type;
    logic [`CU_SHIFT_AMT_WIDTH-1:0]   shift_amount;
    logic                             shift_latch_amt;
    logic                             shift_use_latch;
    logic                             shift_use_rrx;
    alu_op_e                          alu_op;
    alu_wb_e                          alu_writeback;
    logic                             alu_set_flags;
    logic                             alu_latch_op_b;
    logic                             alu_disable_op_b;
    logic                             alu_use_op_b_latch;
    logic                             pc_rn_add_4;
    logic                             pc_rm_add_4;
    logic                             pc_rs_add_4;
    logic                             mem_read_en;
    logic                             mem_write_en;
    logic                             mem_byte;
    logic                             pipeline_advance;
  } control_t;

  // ==========================================================================
  // Helpers
  // ==========================================================================

  // Compare and test opcodes only update flags
  function automatic alu_wb_e dataproc_writeback(alu_op_e op);
    case (op)
      alu_tst, alu_teq, alu_cmp, alu_cmn: return alu_wb_none;
      default: return alu_wb_reg_rd;
    endcase
  endfunction

  // ROR #0 in a shift-by-immediate encodes RRX
  function automatic logic is_rrx(shift_type_e st, logic [`CU_SHIFT_AMT_WIDTH-1:0] amt);
    return (st == shift_ror) && (amt == '0);
  endfunction

  // Prefetch the next instruction and keep PC + 4
  function automatic control_t fetch_next();
    control_t c;
    c = '0;
    c.instr_fetch = 1'b1;
    c.incrementer_writeback = 1'b1;
    c.addr_src = addr_pc;
    return c;
  endfunction

endpackage

//--- source/control_sequencer.sv
`timescale 1ns/1ps
`include "control_settings.svh"

module control_sequencer (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       flush_req,
  input  logic                       condition_pass,
  input  logic                       advance,
  output cpu_pkg::seq_phase_e        phase,
  output logic [`CU_CYCLE_WIDTH-1:0] cycle,
  output cpu_pkg::control_t          idle_control
);

  // 3 = reset prefetch, 2 = flush fetch, 1 = flush advance, 0 = running
  logic [`CU_FLUSH_WIDTH-1:0] flush_cnt;

  always_ff @(posedge clk) begin
    if (reset) begin
      flush_cnt <= `CU_FLUSH_WIDTH'(3);
    end else if (flush_req) begin
      // The fetch half of the flush happens in the request cycle itself
      flush_cnt <= `CU_FLUSH_WIDTH'(1);
    end else if (flush_cnt != '0) begin
      flush_cnt <= flush_cnt - `CU_FLUSH_WIDTH'(1);
    end
  end

  // Cycle within the current instruction
  always_ff @(posedge clk) begin
    if (reset || advance) begin
      cycle <= '0;
    end else begin
      cycle <= cycle + `CU_CYCLE_WIDTH'(1);
    end
  end

  // Reset prefetch wins over a pending flush request
  always_comb begin
    if (flush_cnt == `CU_FLUSH_WIDTH'(3)) begin
      phase = cpu_pkg::phase_reset_prefetch;
    end else if (flush_cnt == `CU_FLUSH_WIDTH'(2) || flush_req) begin
      phase = cpu_pkg::phase_flush_fetch;
    end else if (flush_cnt == `CU_FLUSH_WIDTH'(1)) begin
      phase = cpu_pkg::phase_flush_advance;
    end else if (!condition_pass) begin
      phase = cpu_pkg::phase_skip;
    end else begin
      phase = cpu_pkg::phase_execute;
    end
  end

  // ==========================================================================
  // Fixed control words outside execute
  // ==========================================================================

  always_comb begin
    idle_control = '0;
    case (phase)
      cpu_pkg::phase_reset_prefetch: begin
        idle_control.addr_src = cpu_pkg::addr_pc;
      end
      cpu_pkg::phase_flush_fetch: begin
        idle_control = cpu_pkg::fetch_next();
        idle_control.addr_src = cpu_pkg::addr_incr;
      end
      // Failed condition retires exactly like the end of a flush
      cpu_pkg::phase_flush_advance, cpu_pkg::phase_skip: begin
        idle_control = cpu_pkg::fetch_next();
        idle_control.pipeline_advance = 1'b1;
      end
      default: idle_control = '0;
    endcase
  end

endmodule

//--- source/dataproc_control.sv
`timescale 1ns/1ps
`include "control_settings.svh"

module dataproc_control (
  input  cpu_pkg::decoded_word_t     word,
  input  logic [`CU_CYCLE_WIDTH-1:0] cycle,
  output cpu_pkg::control_t          control
);

  localparam logic [`CU_REG_IDX_WIDTH-1:0] PC_IDX = `CU_REG_IDX_WIDTH'(`CU_PC_REG);

  // Fields shared by the last cycle of every data processing form
  cpu_pkg::control_t complete_word;

  always_comb begin
    complete_word = cpu_pkg::fetch_next();
    complete_word.alu_op = word.opcode;
    complete_word.alu_writeback = cpu_pkg::dataproc_writeback(word.opcode);
    complete_word.alu_set_flags = word.set_flags;
    complete_word.pipeline_advance = 1'b1;
  end

  always_comb begin
    control = '0;
    case (word.instr_type)

      // ======================================================================
      // Rotated 8-bit immediate
      // ======================================================================
      cpu_pkg::instr_dataproc_imm: begin
        control = complete_word;
        control.b_src = cpu_pkg::b_src_imm;
        control.b_imm = `CU_IMM_WIDTH'(word.imm8);
        control.shift_type = cpu_pkg::shift_ror;
        // Rotate field counts in steps of two
        control.shift_amount = {word.rotate, 1'b0};
      end

      // ======================================================================
      // Register shifted by immediate
      // ======================================================================
      cpu_pkg::instr_dataproc_reg_imm: begin
        control = complete_word;
        control.b_src = cpu_pkg::b_src_reg_rm;
        control.shift_type = word.shift_type;
        control.shift_amount = word.shift_amount;
        control.shift_use_rrx = cpu_pkg::is_rrx(word.shift_type, word.shift_amount);
      end

      // ======================================================================
      // Register shifted by register
      // ======================================================================
      cpu_pkg::instr_dataproc_reg_reg: begin
        if (cycle == '0) begin
          // Internal cycle, read Rs into the shift amount latch
          control.b_src = cpu_pkg::b_src_reg_rs;
          control.shift_latch_amt = 1'b1;
          control.pc_rs_add_4 = (word.rs == PC_IDX);
        end else if (cycle == `CU_CYCLE_WIDTH'(1)) begin
          control = complete_word;
          control.b_src = cpu_pkg::b_src_reg_rm;
          control.shift_type = word.shift_type;
          control.shift_use_latch = 1'b1;
          // PC reads as one word further ahead after the extra cycle
          control.pc_rn_add_4 = (word.rn == PC_IDX);
          control.pc_rm_add_4 = (word.rm == PC_IDX);
        end
      end

      default: control = '0;
    endcase
  end

endmodule

//--- source/load_store_control.sv
`timescale 1ns/1ps
`include "control_settings.svh"

module load_store_control (
  input  cpu_pkg::decoded_word_t     word,
  input  logic [`CU_CYCLE_WIDTH-1:0] cycle,
  output cpu_pkg::control_t          control
);

  logic             is_load;
  logic             is_store;
  logic             base_writeback;
  cpu_pkg::alu_op_e offset_op;

  assign is_load = (word.instr_type == cpu_pkg::instr_load);
  assign is_store = (word.instr_type == cpu_pkg::instr_store);

  // Post-index always updates the base, pre-index only with W
  assign base_writeback = !word.pre_index || word.writeback;

  // U selects add or subtract of the offset
  assign offset_op = word.up ? cpu_pkg::alu_add : cpu_pkg::alu_sub;

  always_comb begin
    control = '0;
    if (is_load || is_store) begin
      if (cycle == '0) begin
        // ====================================================================
        // Address calculation, overlapped with the prefetch
        // ====================================================================
        control = cpu_pkg::fetch_next();
        control.addr_src = cpu_pkg::addr_alu;
        control.alu_op = offset_op;

        if (!word.pre_index) begin
          // base goes out unmodified, offset kept for the update
          control.alu_disable_op_b = 1'b1;
          control.alu_latch_op_b = 1'b1;
        end else if (word.writeback) begin
          control.alu_latch_op_b = 1'b1;
        end

        if (!word.reg_offset) begin
          control.b_src = cpu_pkg::b_src_imm;
          control.b_imm = word.imm12;
          control.shift_type = cpu_pkg::shift_lsl;
          control.shift_amount = '0;
        end else begin
          control.b_src = cpu_pkg::b_src_reg_rm;
          control.shift_type = word.shift_type;
          control.shift_amount = word.shift_amount;
          control.shift_use_rrx = cpu_pkg::is_rrx(word.shift_type, word.shift_amount);
        end
      end else if (cycle == `CU_CYCLE_WIDTH'(1)) begin
        // ====================================================================
        // Memory access and base update
        // ====================================================================
        control.addr_src = cpu_pkg::addr_pc;
        control.alu_op = offset_op;
        control.mem_byte = word.byte_xfer;

        if (base_writeback) begin
          control.alu_use_op_b_latch = 1'b1;
          control.alu_writeback = cpu_pkg::alu_wb_reg_rn;
        end

        if (is_load) begin
          control.mem_read_en = 1'b1;
        end else begin
          // Store data comes from Rd, store retires here
          control.mem_write_en = 1'b1;
          control.b_src = cpu_pkg::b_src_reg_rd;
          control.pipeline_advance = 1'b1;
        end
      end else if (cycle == `CU_CYCLE_WIDTH'(2) && is_load) begin
        // Read data passes through the ALU into Rd
        control.addr_src = cpu_pkg::addr_pc;
        control.alu_op = cpu_pkg::alu_mov;
        control.b_src = cpu_pkg::b_src_read_data;
        control.alu_writeback = cpu_pkg::alu_wb_reg_rd;
        control.mem_byte = word.byte_xfer;
        control.pipeline_advance = 1'b1;
      end
    end
  end

endmodule

//--- source/control_unit.sv
`timescale 1ns/1ps
`include "control_settings.svh"

module control_unit (
  input  logic                   clk,
  input  logic                   reset,
  input  cpu_pkg::decoded_word_t word,
  input  logic                   flush_req,
  output cpu_pkg::control_t      control
);

  cpu_pkg::seq_phase_e        phase;
  logic [`CU_CYCLE_WIDTH-1:0] cycle;
  logic                       advance;
  cpu_pkg::control_t          idle_control;
  cpu_pkg::control_t          dataproc_word;
  cpu_pkg::control_t          load_store_word;

  control_sequencer control_sequencer_i (
    .clk            (clk),
    .reset          (reset),
    .flush_req      (flush_req),
    .condition_pass (word.condition_pass),
    .advance        (advance),
    .phase          (phase),
    .cycle          (cycle),
    .idle_control   (idle_control)
  );

  dataproc_control dataproc_control_i (
    .word    (word),
    .cycle   (cycle),
    .control (dataproc_word)
  );

  load_store_control load_store_control_i (
    .word    (word),
    .cycle   (cycle),
    .control (load_store_word)
  );

  // Execute word by instruction class, fixed words otherwise
  always_comb begin
    if (phase != cpu_pkg::phase_execute) begin
      control = idle_control;
    end else begin
      case (word.instr_type)
        cpu_pkg::instr_dataproc_imm,
        cpu_pkg::instr_dataproc_reg_imm,
        cpu_pkg::instr_dataproc_reg_reg: control = dataproc_word;
        cpu_pkg::instr_load,
        cpu_pkg::instr_store: control = load_store_word;
        default: control = '0;
      endcase
    end
  end

  // Last cycle of the word restarts the cycle counter
  assign advance = control.pipeline_advance;

endmodule

//--- test/tb_control_unit.sv
`timescale 1ns/1ps
`include "control_settings.svh"

module tb_control_unit;

  localparam int NUM_ROWS = 17;
  localparam int TIMEOUT_CYCLES = 16 + 3 + 4 * NUM_ROWS + 20;
  localparam logic [`CU_REG_IDX_WIDTH-1:0] PC_REG = `CU_REG_IDX_WIDTH'(`CU_PC_REG);

  logic                   clk;
  logic                   reset;
  cpu_pkg::decoded_word_t word;
  logic                   flush_req;
  cpu_pkg::control_t      control;

  // Stimulus table with one instruction per row
  string                  row_name[NUM_ROWS];
  cpu_pkg::decoded_word_t row_word[NUM_ROWS];
  int                     row_flush_at[NUM_ROWS];
  int                     row_length[NUM_ROWS];
  bit                     row_random[NUM_ROWS];
  int                     row_count;

  integer seed;
  int     error_count;
  int     tests_run;
  int     tests_passed;
  int     cycle_count;

  control_unit control_unit_i (
    .clk       (clk),
    .reset     (reset),
    .word      (word),
    .flush_req (flush_req),
    .control   (control)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the run did not finish", cycle_count);
      $display("Some tests failed");
      $finish;
    end
  end

  // ==========================================================================
  // Reference model of the control word
  // ==========================================================================

  function automatic cpu_pkg::control_t fixed_word(input cpu_pkg::seq_phase_e ph);
    cpu_pkg::control_t c;
    c = '0;
    c.addr_src = cpu_pkg::addr_pc;
    if (ph != cpu_pkg::phase_reset_prefetch) begin
      c.instr_fetch = 1'b1;
      c.incrementer_writeback = 1'b1;
    end
    if (ph == cpu_pkg::phase_flush_fetch) begin
      c.addr_src = cpu_pkg::addr_incr;
    end
    if (ph == cpu_pkg::phase_flush_advance || ph == cpu_pkg::phase_skip) begin
      c.pipeline_advance = 1'b1;
    end
    return c;
  endfunction

  // Last cycle of any data processing form
  function automatic cpu_pkg::control_t retire_dataproc(input cpu_pkg::decoded_word_t w);
    cpu_pkg::control_t c;
    c = '0;
    c.instr_fetch = 1'b1;
    c.incrementer_writeback = 1'b1;
    c.addr_src = cpu_pkg::addr_pc;
    c.alu_op = w.opcode;
    c.alu_set_flags = w.set_flags;
    c.pipeline_advance = 1'b1;
    if (w.opcode inside {cpu_pkg::alu_tst, cpu_pkg::alu_teq, cpu_pkg::alu_cmp,
                         cpu_pkg::alu_cmn}) begin
      c.alu_writeback = cpu_pkg::alu_wb_none;
    end else begin
      c.alu_writeback = cpu_pkg::alu_wb_reg_rd;
    end
    return c;
  endfunction

  function automatic cpu_pkg::control_t expected_control(
    input cpu_pkg::decoded_word_t w,
    input int                     cyc,
    input int                     flush_at
  );
    cpu_pkg::control_t c;
    logic              is_load;
    c = '0;
    is_load = (w.instr_type == cpu_pkg::instr_load);
    if (flush_at >= 0 && cyc == flush_at) begin
      return fixed_word(cpu_pkg::phase_flush_fetch);
    end
    if (flush_at >= 0 && cyc == flush_at + 1) begin
      return fixed_word(cpu_pkg::phase_flush_advance);
    end
    if (!w.condition_pass) begin
      return (cyc == 0) ? fixed_word(cpu_pkg::phase_skip) : c;
    end
    case (w.instr_type)
      cpu_pkg::instr_dataproc_imm: begin
        if (cyc == 0) begin
          c = retire_dataproc(w);
          c.b_src = cpu_pkg::b_src_imm;
          c.b_imm = 12'(w.imm8);
          c.shift_type = cpu_pkg::shift_ror;
          c.shift_amount = 5'(w.rotate) * 5'd2;
        end
      end
      cpu_pkg::instr_dataproc_reg_imm: begin
        if (cyc == 0) begin
          c = retire_dataproc(w);
          c.b_src = cpu_pkg::b_src_reg_rm;
          c.shift_type = w.shift_type;
          c.shift_amount = w.shift_amount;
          c.shift_use_rrx = (w.shift_type == cpu_pkg::shift_ror) && (w.shift_amount == '0);
        end
      end
      cpu_pkg::instr_dataproc_reg_reg: begin
        if (cyc == 0) begin
          c.b_src = cpu_pkg::b_src_reg_rs;
          c.shift_latch_amt = 1'b1;
          c.pc_rs_add_4 = (w.rs == PC_REG);
        end else if (cyc == 1) begin
          c = retire_dataproc(w);
          c.b_src = cpu_pkg::b_src_reg_rm;
          c.shift_type = w.shift_type;
          c.shift_use_latch = 1'b1;
          c.pc_rn_add_4 = (w.rn == PC_REG);
          c.pc_rm_add_4 = (w.rm == PC_REG);
        end
      end
      cpu_pkg::instr_load, cpu_pkg::instr_store: begin
        if (cyc == 0) begin
          c.instr_fetch = 1'b1;
          c.incrementer_writeback = 1'b1;
          c.addr_src = cpu_pkg::addr_alu;
          c.alu_op = w.up ? cpu_pkg::alu_add : cpu_pkg::alu_sub;
          c.alu_disable_op_b = !w.pre_index;
          c.alu_latch_op_b = !w.pre_index || w.writeback;
          if (w.reg_offset) begin
            c.b_src = cpu_pkg::b_src_reg_rm;
            c.shift_type = w.shift_type;
            c.shift_amount = w.shift_amount;
            c.shift_use_rrx = (w.shift_type == cpu_pkg::shift_ror) && (w.shift_amount == '0);
          end else begin
            c.b_src = cpu_pkg::b_src_imm;
            c.b_imm = w.imm12;
          end
        end else if (cyc == 1) begin
          c.addr_src = cpu_pkg::addr_pc;
          c.alu_op = w.up ? cpu_pkg::alu_add : cpu_pkg::alu_sub;
          c.mem_byte = w.byte_xfer;
          if (!w.pre_index || w.writeback) begin
            c.alu_use_op_b_latch = 1'b1;
            c.alu_writeback = cpu_pkg::alu_wb_reg_rn;
          end
          c.mem_read_en = is_load;
          c.mem_write_en = !is_load;
          c.pipeline_advance = !is_load;
          if (!is_load) begin
            c.b_src = cpu_pkg::b_src_reg_rd;
          end
        end else if (cyc == 2 && is_load) begin
          c.addr_src = cpu_pkg::addr_pc;
          c.alu_op = cpu_pkg::alu_mov;
          c.b_src = cpu_pkg::b_src_read_data;
          c.alu_writeback = cpu_pkg::alu_wb_reg_rd;
          c.mem_byte = w.byte_xfer;
          c.pipeline_advance = 1'b1;
        end
      end
      default: c = '0;
    endcase
    return c;
  endfunction

  // ==========================================================================
  // Table construction
  // ==========================================================================

  function automatic cpu_pkg::decoded_word_t base_word(
    input cpu_pkg::instr_type_e t,
    input cpu_pkg::alu_op_e     op
  );
    cpu_pkg::decoded_word_t w;
    w = '0;
    w.instr_type = t;
    w.condition_pass = 1'b1;
    w.rn = 4'd2;
    w.rd = 4'd1;
    w.rs = 4'd4;
    w.rm = 4'd3;
    w.opcode = op;
    return w;
  endfunction

  function automatic cpu_pkg::decoded_word_t transfer_word(
    input cpu_pkg::instr_type_e t,
    input logic pre,
    input logic up,
    input logic byte_xfer,
    input logic wb,
    input logic reg_off
  );
    cpu_pkg::decoded_word_t w;
    w = base_word(t, cpu_pkg::alu_and);
    w.pre_index = pre;
    w.up = up;
    w.byte_xfer = byte_xfer;
    w.writeback = wb;
    w.reg_offset = reg_off;
    w.imm12 = 12'h0a4;
    w.shift_type = cpu_pkg::shift_lsr;
    w.shift_amount = 5'd2;
    return w;
  endfunction

  task automatic add_row(
    input string                  name,
    input cpu_pkg::decoded_word_t w,
    input int                     flush_at,
    input int                     length,
    input bit                     randomize_regs
  );
    row_name[row_count] = name;
    row_word[row_count] = w;
    row_flush_at[row_count] = flush_at;
    row_length[row_count] = length;
    row_random[row_count] = randomize_regs;
    row_count = row_count + 1;
  endtask

  task automatic build_table();
    cpu_pkg::decoded_word_t w;
    w = base_word(cpu_pkg::instr_dataproc_imm, cpu_pkg::alu_add);
    w.imm8 = 8'h3c;
    w.rotate = 4'd4;
    w.set_flags = 1'b1;
    add_row("dp_imm_add_ror8", w, -1, 1, 1'b0);
    w = base_word(cpu_pkg::instr_dataproc_imm, cpu_pkg::alu_cmp);
    w.imm8 = 8'hff;
    w.rotate = 4'd15;
    add_row("dp_imm_cmp", w, -1, 1, 1'b0);
    w = base_word(cpu_pkg::instr_dataproc_reg_imm, cpu_pkg::alu_sub);
    w.shift_amount = 5'd3;
    add_row("dp_reg_lsl3", w, -1, 1, 1'b0);
    w = base_word(cpu_pkg::instr_dataproc_reg_imm, cpu_pkg::alu_orr);
    w.shift_type = cpu_pkg::shift_ror;
    add_row("dp_reg_rrx", w, -1, 1, 1'b0);
    w = base_word(cpu_pkg::instr_dataproc_reg_imm, cpu_pkg::alu_tst);
    w.shift_type = cpu_pkg::shift_ror;
    w.shift_amount = 5'd7;
    add_row("dp_reg_ror7", w, -1, 1, 1'b0);
    w = base_word(cpu_pkg::instr_dataproc_reg_imm, cpu_pkg::alu_eor);
    w.shift_type = cpu_pkg::shift_asr;
    w.shift_amount = 5'd31;
    add_row("dp_reg_asr_random", w, -1, 1, 1'b1);
    w = base_word(cpu_pkg::instr_dataproc_reg_reg, cpu_pkg::alu_add);
    w.rn = 4'd15;
    w.rs = 4'd15;
    w.shift_type = cpu_pkg::shift_lsr;
    add_row("dp_regreg_pc", w, -1, 2, 1'b0);
    w = base_word(cpu_pkg::instr_dataproc_reg_reg, cpu_pkg::alu_cmn);
    w.rm = 4'd15;
    w.shift_type = cpu_pkg::shift_asr;
    w.set_flags = 1'b1;
    add_row("dp_regreg_pc_rm", w, -1, 2, 1'b0);
    w = base_word(cpu_pkg::instr_dataproc_reg_reg, cpu_pkg::alu_bic);
    w.shift_type = cpu_pkg::shift_ror;
    add_row("dp_regreg_random", w, -1, 2, 1'b1);
    add_row("ldr_pre_up_imm",
            transfer_word(cpu_pkg::instr_load, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0), -1, 3, 1'b0);
    add_row("ldr_post_down_reg",
            transfer_word(cpu_pkg::instr_load, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1), -1, 3, 1'b0);
    w = transfer_word(cpu_pkg::instr_load, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1);
    w.shift_type = cpu_pkg::shift_ror;
    w.shift_amount = 5'd0;
    add_row("ldrb_pre_wb_rrx", w, -1, 3, 1'b0);
    add_row("str_pre_down_wb_imm",
            transfer_word(cpu_pkg::instr_store, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0), -1, 2, 1'b0);
    add_row("strb_post_up_reg",
            transfer_word(cpu_pkg::instr_store, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1), -1, 2, 1'b1);
    w = transfer_word(cpu_pkg::instr_load, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0);
    w.condition_pass = 1'b0;
    add_row("ldr_cond_fail", w, -1, 1, 1'b0);
    add_row("ldr_flush_cycle1",
            transfer_word(cpu_pkg::instr_load, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0), 1, 3, 1'b0);
    w = base_word(cpu_pkg::instr_dataproc_imm, cpu_pkg::alu_mov);
    w.imm8 = 8'h55;
    add_row("dp_imm_after_flush", w, -1, 1, 1'b0);
  endtask

  // ==========================================================================
  // Checking and row execution
  // ==========================================================================

  task automatic check_value(
    input string       what,
    input logic [63:0] actual,
    input logic [63:0] expected
  );
    if (actual !== expected) begin
      $display("[FAIL] %s: got %h expected %h", what, actual, expected);
      error_count = error_count + 1;
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run = tests_run + 1;
    if (error_count == errors_before) begin
      tests_passed = tests_passed + 1;
      $display("test %-22s ok", name);
    end else begin
      $display("test %-22s FAILED", name);
    end
  endtask

  task automatic run_row(input int idx);
    cpu_pkg::decoded_word_t w;
    int                     cyc;
    int                     errors_before;
    logic                   done;
    w = row_word[idx];
    errors_before = error_count;
    if (row_random[idx]) begin
      w.rn = 4'($random(seed));
      w.rd = 4'($random(seed));
      w.rs = 4'($random(seed));
      w.rm = 4'($random(seed));
      w.opcode = cpu_pkg::alu_op_e'(4'($random(seed)));
    end
    cyc = 0;
    done = 1'b0;
    while (!done && cyc < 4) begin
      @(negedge clk);
      word = w;
      flush_req = (cyc == row_flush_at[idx]);
      #1;
      check_value($sformatf("%s control[%0d]", row_name[idx], cyc), 64'(control),
                  64'(expected_control(w, cyc, row_flush_at[idx])));
      done = control.pipeline_advance;
      cyc = cyc + 1;
    end
    if (!done) begin
      $display("%s never raised pipeline_advance within 4 cycles", row_name[idx]);
      error_count = error_count + 1;
    end
    check_value($sformatf("%s length", row_name[idx]), 64'(cyc), 64'(row_length[idx]));
    finish_test(row_name[idx], errors_before);
  endtask

  initial begin
    cpu_pkg::seq_phase_e startup[3];
    int                  errors_before;
    clk = 1'b0;
    reset = 1'b1;
    word = '0;
    flush_req = 1'b0;
    seed = 32'hd7ad_bbc5;
    error_count = 0;
    tests_run = 0;
    tests_passed = 0;
    cycle_count = 0;
    row_count = 0;
    build_table();

    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Three phase start-up flush
    startup[0] = cpu_pkg::phase_reset_prefetch;
    startup[1] = cpu_pkg::phase_flush_fetch;
    startup[2] = cpu_pkg::phase_flush_advance;
    errors_before = error_count;
    for (int i = 0; i < 3; i++) begin
      if (i > 0) begin
        @(negedge clk);
      end
      #1;
      check_value($sformatf("startup control[%0d]", i), 64'(control),
                  64'(fixed_word(startup[i])));
    end
    finish_test("startup_flush", errors_before);

    for (int i = 0; i < row_count; i++) begin
      run_row(i);
    end

    $display("Summary: %0d tests, %0d passed, %0d failed, %0d check errors",
             tests_run, tests_passed, tests_run - tests_passed, error_count);
    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+include
source/cpu_pkg.sv
source/control_sequencer.sv
source/dataproc_control.sv
source/load_store_control.sv
source/control_unit.sv
test/tb_control_unit.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the control unit testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f verilog.f --top-module tb_control_unit \
    -o tb_control_unit; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/tb_control_unit)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "All tests passed"; then
  exit 0
fi
exit 1
